// File: common/route_pkg.sv
/*
 * Shared switch constants and frame types
 * Round-robin pick helper used by the table and the transmit arbiters
 */
`default_nettype none

package route_pkg;

	// Port count and beat geometry
	localparam int NETH       = 4;
	localparam int PKTDW      = 32;
	localparam int PKTBYW     = 2;
	localparam int MACW       = 48;

	// Route table size
	localparam int LGROUTETBL = 3;
	localparam int NROUTE     = 1 << LGROUTETBL;

	typedef logic [PKTDW-1:0]        beat_t;
	// Zero means all four bytes valid
	typedef logic [PKTBYW-1:0]       bytes_t;
	typedef logic [MACW-1:0]         mac_t;
	typedef logic [NETH-1:0]         port_mask_t;
	typedef logic [$clog2(NETH)-1:0] port_idx_t;

	// First set request at or after start, wrapping around
	function automatic port_idx_t rr_pick(input port_mask_t req, input port_idx_t start);
		port_idx_t idx;
		port_idx_t pick;
		logic      found;
		pick  = start;
		found = 1'b0;
		for (int k = 0; k < NETH; k++)
		begin
			idx = port_idx_t'(start + k);
			if (!found && req[idx])
			begin
				pick  = idx;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

// File: design/port/rx_srcmac.sv
/*
 * Receive register stage with beat counter
 * Pulls the source MAC out of beats 1 and 2 and offers it for learning
 */
`timescale 1ns/1ps
`default_nettype none

module rx_srcmac (
	input  wire logic              i_clk,
	input  wire logic              i_reset,
	input  wire logic              i_off,
	input  wire logic              i_valid,
	output logic                   o_ready,
	input  wire route_pkg::beat_t  i_data,
	input  wire route_pkg::bytes_t i_bytes,
	input  wire logic              i_last,
	output logic                   o_valid,
	input  wire logic              i_ready,
	output route_pkg::beat_t       o_data,
	output route_pkg::bytes_t      o_bytes,
	output logic                   o_last,
	output logic                   o_learn_valid,
	input  wire logic              i_learn_ready,
	output route_pkg::mac_t        o_learn_mac
);
	logic        r_en;
	logic [1:0]  beat_cnt;
	logic [15:0] mac_hi;
	logic        accept;
	logic        learn_stall;

	// Hold beat 2 while the previous learn still waits on the table
	assign learn_stall = (beat_cnt == 2'd2) && o_learn_valid && !i_learn_ready;
	assign o_ready = r_en && !i_off && (!o_valid || i_ready) && !learn_stall;
	assign accept  = i_valid && o_ready;

	// Keeps ready low through reset and the first cycle after it
	always_ff @(posedge i_clk)
		if (i_reset)
			r_en <= 1'b0;
		else
			r_en <= !i_off;

	always_ff @(posedge i_clk)
		if (i_reset || i_off)
		begin
			o_valid       <= 1'b0;
			beat_cnt      <= 2'd0;
			o_learn_valid <= 1'b0;
		end
		else
		begin
			if (accept)
				o_valid <= 1'b1;
			else if (i_ready)
				o_valid <= 1'b0;
			// Count saturates at 3, the header is done by then
			if (accept && i_last)
				beat_cnt <= 2'd0;
			else if (accept && beat_cnt != 2'd3)
				beat_cnt <= beat_cnt + 2'd1;
			// New learn wins over the handshake of the old one
			if (accept && beat_cnt == 2'd2)
				o_learn_valid <= 1'b1;
			else if (i_learn_ready)
				o_learn_valid <= 1'b0;
		end

	// Payload path
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			o_data  <= i_data;
			o_bytes <= i_bytes;
			o_last  <= i_last;
		end
		// Source MAC top half sits low in beat 1
		if (accept && beat_cnt == 2'd1)
			mac_hi <= i_data[15:0];
		if (accept && beat_cnt == 2'd2)
			o_learn_mac <= {mac_hi, i_data};
	end

endmodule

`default_nettype wire

// File: design/port/tx_dstport.sv
/*
 * Destination lookup stage
 * Buffers beats 0 and 1, asks the route table, tags the frame with a mask
 */
`timescale 1ns/1ps
`default_nettype none

module tx_dstport #(
	parameter route_pkg::port_idx_t SELF_PORT = '0
) (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire logic                  i_valid,
	output logic                       o_ready,
	input  wire route_pkg::beat_t      i_data,
	input  wire route_pkg::bytes_t     i_bytes,
	input  wire logic                  i_last,
	output logic                       o_lkup_req,
	output route_pkg::mac_t            o_lkup_mac,
	input  wire logic                  i_lkup_ack,
	input  wire logic                  i_lkup_hit,
	input  wire route_pkg::port_idx_t  i_lkup_port,
	input  wire route_pkg::port_mask_t i_port_off,
	output logic                       o_valid,
	input  wire logic                  i_ready,
	output route_pkg::beat_t           o_data,
	output route_pkg::bytes_t          o_bytes,
	output logic                       o_last,
	output route_pkg::port_mask_t      o_mask
);
	import route_pkg::*;

	typedef enum logic [2:0] {
		S_HDR0, S_HDR1, S_LKUP, S_REP0, S_REP1, S_PASS, S_DRAIN
	} state_t;

	state_t     state;
	beat_t      hdr0, hdr1;
	port_mask_t new_mask;
	logic       in_take;

	assign o_lkup_req = (state == S_LKUP);
	assign o_lkup_mac = {hdr0, hdr1[31:16]};
	assign in_take    = i_valid && o_ready;

	// Hit goes to one port, miss floods; never back home, never to an off port
	assign new_mask = (i_lkup_hit ? (port_mask_t'(1) << i_lkup_port) : '1)
		& ~(port_mask_t'(1) << SELF_PORT) & ~i_port_off;

	always_ff @(posedge i_clk)
		if (i_reset)
			state <= S_HDR0;
		else
			case (state)
			S_HDR0:  if (in_take) state <= S_HDR1;
			S_HDR1:  if (in_take) state <= S_LKUP;
			S_LKUP:  if (i_lkup_ack) state <= (new_mask == '0) ? S_DRAIN : S_REP0;
			S_REP0:  if (i_ready) state <= S_REP1;
			S_REP1:  if (i_ready) state <= S_PASS;
			default: if (in_take && i_last) state <= S_HDR0;
			endcase

	// Header beats and the routing result
	always_ff @(posedge i_clk)
	begin
		if (state == S_HDR0 && in_take)
			hdr0 <= i_data;
		if (state == S_HDR1 && in_take)
			hdr1 <= i_data;
		if (state == S_LKUP && i_lkup_ack)
			o_mask <= new_mask;
	end

	// Header beats are never last and always full width
	always_comb
	begin
		o_data  = i_data;
		o_bytes = i_bytes;
		o_last  = i_last;
		o_valid = 1'b0;
		o_ready = 1'b0;
		case (state)
		S_HDR0, S_HDR1, S_DRAIN: o_ready = 1'b1;
		S_REP0, S_REP1:
		begin
			o_valid = 1'b1;
			o_data  = (state == S_REP0) ? hdr0 : hdr1;
			o_bytes = '0;
			o_last  = 1'b0;
		end
		S_PASS:
		begin
			o_valid = i_valid;
			o_ready = i_ready;
		end
		default: o_ready = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/table/route_table.sv
/*
 * Shared MAC-to-port route table
 * Learn and lookup requests are granted round-robin, one of each per cycle
 * New MACs fill the slot under a write pointer, so the oldest slot goes first
 */
`timescale 1ns/1ps
`default_nettype none

module route_table (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire route_pkg::port_mask_t i_learn_valid,
	output route_pkg::port_mask_t      o_learn_ready,
	input  wire route_pkg::mac_t       i_learn_mac [route_pkg::NETH],
	input  wire route_pkg::port_mask_t i_lkup_req,
	input  wire route_pkg::mac_t       i_lkup_mac [route_pkg::NETH],
	output route_pkg::port_mask_t      o_lkup_ack,
	output logic                       o_lkup_hit,
	output route_pkg::port_idx_t       o_lkup_port
);
	import route_pkg::*;

	logic                  ent_valid [NROUTE];
	mac_t                  ent_mac   [NROUTE];
	port_idx_t             ent_port  [NROUTE];
	logic [LGROUTETBL-1:0] wr_ptr;
	port_idx_t             learn_rr, lkup_rr;
	port_idx_t             learn_win, lkup_win;
	logic                  learn_any, lkup_any;
	port_mask_t            lkup_elig;
	mac_t                  learn_key, lkup_key;
	logic                  learn_match, lkup_match;
	logic [LGROUTETBL-1:0] learn_slot;
	port_idx_t             lkup_found;

	//////////////////////////////////////////////////
	// Grants
	//////////////////////////////////////////////////

	assign learn_any     = |i_learn_valid;
	assign learn_win     = rr_pick(i_learn_valid, learn_rr);
	assign learn_key     = i_learn_mac[learn_win];
	// The learning port is the winner itself
	assign o_learn_ready = learn_any ? (port_mask_t'(1) << learn_win) : '0;

	// A requester waiting for its ack is skipped
	assign lkup_elig = i_lkup_req & ~o_lkup_ack;
	assign lkup_any  = |lkup_elig;
	assign lkup_win  = rr_pick(lkup_elig, lkup_rr);
	assign lkup_key  = i_lkup_mac[lkup_win];

	//////////////////////////////////////////////////
	// Searches over the current table contents
	//////////////////////////////////////////////////

	always_comb
	begin
		learn_match = 1'b0;
		learn_slot  = wr_ptr;
		for (int i = 0; i < NROUTE; i++)
			if (!learn_match && ent_valid[i] && ent_mac[i] == learn_key)
			begin
				learn_match = 1'b1;
				learn_slot  = LGROUTETBL'(i);
			end
	end

	always_comb
	begin
		lkup_match = 1'b0;
		lkup_found = '0;
		for (int i = 0; i < NROUTE; i++)
			if (!lkup_match && ent_valid[i] && ent_mac[i] == lkup_key)
			begin
				lkup_match = 1'b1;
				lkup_found = ent_port[i];
			end
	end

	//////////////////////////////////////////////////
	// Table update and lookup answer
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			for (int i = 0; i < NROUTE; i++)
				ent_valid[i] <= 1'b0;
			wr_ptr     <= '0;
			learn_rr   <= '0;
			lkup_rr    <= '0;
			o_lkup_ack <= '0;
		end
		else
		begin
			if (learn_any)
			begin
				ent_valid[learn_slot] <= 1'b1;
				// Only a fresh MAC consumes a slot
				if (!learn_match)
					wr_ptr <= wr_ptr + 1'b1;
				learn_rr <= port_idx_t'(learn_win + 1'b1);
			end
			o_lkup_ack <= lkup_any ? (port_mask_t'(1) << lkup_win) : '0;
			if (lkup_any)
				lkup_rr <= port_idx_t'(lkup_win + 1'b1);
		end

	// Lookup reads the old contents, so a same-cycle learn is not seen
	always_ff @(posedge i_clk)
	begin
		if (learn_any)
		begin
			ent_mac[learn_slot]  <= learn_key;
			ent_port[learn_slot] <= learn_win;
		end
		o_lkup_hit  <= lkup_match;
		o_lkup_port <= lkup_found;
	end

endmodule

`default_nettype wire

// File: design/xbar/pkt_broadcast.sv
/*
 * One-to-many beat fan-out
 * Each masked port takes the beat once; the beat retires when all have it
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_broadcast (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire logic                  i_valid,
	output logic                       o_ready,
	input  wire route_pkg::beat_t      i_data,
	input  wire route_pkg::bytes_t     i_bytes,
	input  wire logic                  i_last,
	input  wire route_pkg::port_mask_t i_mask,
	output route_pkg::port_mask_t      o_valid,
	input  wire route_pkg::port_mask_t i_ready,
	output route_pkg::beat_t           o_data,
	output route_pkg::bytes_t          o_bytes,
	output logic                       o_last
);
	import route_pkg::*;

	// Ports that already took the current beat
	port_mask_t done;
	port_mask_t taken;

	// Offer only to masked ports still waiting
	assign o_valid = {NETH{i_valid}} & i_mask & ~done;
	assign taken   = done | (o_valid & i_ready);

	// Beat is finished once every masked port is covered
	assign o_ready = ((taken & i_mask) == i_mask);

	// Same beat for every destination
	assign o_data  = i_data;
	assign o_bytes = i_bytes;
	assign o_last  = i_last;

	always_ff @(posedge i_clk)
		if (i_reset)
			done <= '0;
		else if (i_valid && o_ready)
			done <= '0;
		else
			done <= taken;

endmodule

`default_nettype wire

// File: design/xbar/pkt_arbiter.sv
/*
 * Transmit arbiter for one output port
 * Round-robin over sources, locked to one source until its last beat
 * Registered output stage with one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_arbiter (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire route_pkg::port_mask_t i_valid,
	output route_pkg::port_mask_t      o_ready,
	input  wire route_pkg::beat_t      i_data [route_pkg::NETH],
	input  wire route_pkg::bytes_t     i_bytes [route_pkg::NETH],
	input  wire route_pkg::port_mask_t i_last,
	output logic                       o_valid,
	input  wire logic                  i_ready,
	output route_pkg::beat_t           o_data,
	output route_pkg::bytes_t          o_bytes,
	output logic                       o_last
);
	import route_pkg::*;

	logic      locked;
	port_idx_t sel;
	port_idx_t rr;
	port_idx_t pick;
	port_idx_t cur;
	logic      src_ok;
	logic      take;

	// Fresh choice only between frames
	assign pick   = rr_pick(i_valid, rr);
	assign cur    = locked ? sel : pick;
	assign src_ok = locked ? i_valid[sel] : |i_valid;

	// Output register empty or draining this cycle
	assign take    = src_ok && (!o_valid || i_ready);
	assign o_ready = take ? (port_mask_t'(1) << cur) : '0;

	//////////////////////////////////////////////////
	// Frame lock and round-robin pointer
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			locked  <= 1'b0;
			sel     <= '0;
			rr      <= '0;
			o_valid <= 1'b0;
		end
		else
		begin
			if (take)
				o_valid <= 1'b1;
			else if (i_ready)
				o_valid <= 1'b0;
			if (take && i_last[cur])
			begin
				// Frame done, next search starts past this source
				locked <= 1'b0;
				rr     <= port_idx_t'(cur + 1'b1);
			end
			else if (take)
			begin
				locked <= 1'b1;
				sel    <= cur;
			end
		end

	// Output payload
	always_ff @(posedge i_clk)
		if (take)
		begin
			o_data  <= i_data[cur];
			o_bytes <= i_bytes[cur];
			o_last  <= i_last[cur];
		end

endmodule

`default_nettype wire

// File: design/route_core.sv
/*
 * Four-port switch forwarding core
 * Per port: source learning, destination lookup, fan-out and transmit merge
 * One route table shared by all ports
 */
`timescale 1ns/1ps
`default_nettype none

module route_core (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire route_pkg::port_mask_t i_port_off,
	input  wire route_pkg::port_mask_t i_rx_valid,
	output wire route_pkg::port_mask_t o_rx_ready,
	input  wire route_pkg::beat_t      i_rx_data [route_pkg::NETH],
	input  wire route_pkg::bytes_t     i_rx_bytes [route_pkg::NETH],
	input  wire route_pkg::port_mask_t i_rx_last,
	output wire route_pkg::port_mask_t o_tx_valid,
	input  wire route_pkg::port_mask_t i_tx_ready,
	output wire route_pkg::beat_t      o_tx_data [route_pkg::NETH],
	output wire route_pkg::bytes_t     o_tx_bytes [route_pkg::NETH],
	output wire route_pkg::port_mask_t o_tx_last
);
	import route_pkg::*;

	// rx_srcmac to tx_dstport
	wire port_mask_t s_valid, s_ready, s_last;
	wire beat_t      s_data  [NETH];
	wire bytes_t     s_bytes [NETH];

	// Table requests
	wire port_mask_t learn_valid, learn_ready, lkup_req, lkup_ack;
	wire mac_t       learn_mac [NETH];
	wire mac_t       lkup_mac  [NETH];
	wire logic       lkup_hit;
	wire port_idx_t  lkup_port;

	// tx_dstport to pkt_broadcast
	wire port_mask_t d_valid, d_ready, d_last;
	wire beat_t      d_data  [NETH];
	wire bytes_t     d_bytes [NETH];
	wire port_mask_t d_mask  [NETH];

	// Crossbar rows by source, then columns by destination
	wire port_mask_t x_valid [NETH];
	wire beat_t      x_data  [NETH];
	wire bytes_t     x_bytes [NETH];
	wire port_mask_t x_last;
	port_mask_t      x_ready [NETH];
	port_mask_t      a_valid [NETH];
	wire port_mask_t a_ready [NETH];
	beat_t           a_data  [NETH][NETH];
	bytes_t          a_bytes [NETH][NETH];
	port_mask_t      a_last  [NETH];

	//////////////////////////////////////////////////
	// Per-port paths
	//////////////////////////////////////////////////

	for (genvar p = 0; p < NETH; p++)
	begin : g_port
		rx_srcmac u_rx (
			.i_clk(i_clk), .i_reset(i_reset), .i_off(i_port_off[p]),
			.i_valid(i_rx_valid[p]), .o_ready(o_rx_ready[p]),
			.i_data(i_rx_data[p]), .i_bytes(i_rx_bytes[p]), .i_last(i_rx_last[p]),
			.o_valid(s_valid[p]), .i_ready(s_ready[p]),
			.o_data(s_data[p]), .o_bytes(s_bytes[p]), .o_last(s_last[p]),
			.o_learn_valid(learn_valid[p]), .i_learn_ready(learn_ready[p]),
			.o_learn_mac(learn_mac[p])
		);

		tx_dstport #(.SELF_PORT(port_idx_t'(p))) u_dst (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(s_valid[p]), .o_ready(s_ready[p]),
			.i_data(s_data[p]), .i_bytes(s_bytes[p]), .i_last(s_last[p]),
			.o_lkup_req(lkup_req[p]), .o_lkup_mac(lkup_mac[p]),
			.i_lkup_ack(lkup_ack[p]), .i_lkup_hit(lkup_hit),
			.i_lkup_port(lkup_port), .i_port_off(i_port_off),
			.o_valid(d_valid[p]), .i_ready(d_ready[p]),
			.o_data(d_data[p]), .o_bytes(d_bytes[p]), .o_last(d_last[p]),
			.o_mask(d_mask[p])
		);

		pkt_broadcast u_bc (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(d_valid[p]), .o_ready(d_ready[p]),
			.i_data(d_data[p]), .i_bytes(d_bytes[p]), .i_last(d_last[p]),
			.i_mask(d_mask[p]), .o_valid(x_valid[p]), .i_ready(x_ready[p]),
			.o_data(x_data[p]), .o_bytes(x_bytes[p]), .o_last(x_last[p])
		);

		pkt_arbiter u_arb (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(a_valid[p]), .o_ready(a_ready[p]),
			.i_data(a_data[p]), .i_bytes(a_bytes[p]), .i_last(a_last[p]),
			.o_valid(o_tx_valid[p]), .i_ready(i_tx_ready[p]),
			.o_data(o_tx_data[p]), .o_bytes(o_tx_bytes[p]), .o_last(o_tx_last[p])
		);
	end

	// Crossbar transpose so arbiter d sees source s on row s
	always_comb
		for (int d = 0; d < NETH; d++)
			for (int s = 0; s < NETH; s++)
			begin
				a_valid[d][s] = x_valid[s][d];
				a_data[d][s]  = x_data[s];
				a_bytes[d][s] = x_bytes[s];
				a_last[d][s]  = x_last[s];
				x_ready[s][d] = a_ready[d][s];
			end

	route_table u_table (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_learn_valid(learn_valid), .o_learn_ready(learn_ready),
		.i_learn_mac(learn_mac),
		.i_lkup_req(lkup_req), .i_lkup_mac(lkup_mac), .o_lkup_ack(lkup_ack),
		.o_lkup_hit(lkup_hit), .o_lkup_port(lkup_port)
	);

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
/*
 * Testbench clock and synchronous reset source
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clk,
	output logic o_reset
);
	// Free-running clock, 100 ns period by default
	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = ~o_clk;
	end

	// Reset held high for a fixed number of rising edges
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/tb_route_core.sv
/*
 * Directed testbench for the four-port forwarding core
 * Frame builder, per-port receive drivers and transmit capture
 * Route table reference model and per-destination frame checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_route_core;
	import route_pkg::*;

	localparam int   MAXB    = 2048;
	localparam int   MAXF    = 128;
	localparam int   MAXQ    = 32;
	localparam int   TIMEOUT = 4000;
	localparam mac_t MAC_S0  = 48'h02_00_00_00_00_10;
	localparam mac_t MAC_S1  = 48'h02_00_00_00_00_11;
	localparam mac_t MAC_S2  = 48'h02_00_00_00_00_12;
	localparam mac_t MAC_S3  = 48'h02_00_00_00_00_13;
	localparam mac_t MAC_A   = 48'h02_00_00_00_00_a2;
	localparam mac_t MAC_N   = 48'h02_00_00_00_01_00;
	localparam mac_t MAC_UNK = 48'h06_ff_ee_00_00_00;

	wire logic       clk;
	wire logic       reset;
	port_mask_t      port_off, rx_valid, rx_last, tx_ready;
	beat_t           rx_data  [NETH];
	bytes_t          rx_bytes [NETH];
	wire port_mask_t rx_ready, tx_valid, tx_last;
	wire beat_t      tx_data  [NETH];
	wire bytes_t     tx_bytes [NETH];

	// Frame store, one word is {last, bytes, data}
	logic [34:0] fmem [MAXB];
	int          fbase [MAXF];
	int          flen  [MAXF];
	int          nfrm, nbeat;
	// Send lists per receive port
	int          send_id [NETH][MAXQ];
	int          send_n [NETH], send_pos [NETH], beat_pos [NETH];
	// Expected frame ids by destination, then source
	int          exp_id [NETH][NETH][MAXQ];
	int          exp_n  [NETH][NETH];
	// Captured transmit beats
	logic [34:0] cap  [NETH][MAXB];
	int          ncap [NETH];
	// Route table model
	logic        m_valid [NROUTE];
	mac_t        m_mac   [NROUTE];
	port_idx_t   m_port  [NROUTE];
	int          m_wptr;
	int          errors, checks;
	integer      seed;

	tb_clkgen #(.HALF_PERIOD(50), .RESET_CYCLES(10)) clkgen0 (.o_clk(clk), .o_reset(reset));

	route_core dut0 (
		.i_clk(clk), .i_reset(reset), .i_port_off(port_off),
		.i_rx_valid(rx_valid), .o_rx_ready(rx_ready),
		.i_rx_data(rx_data), .i_rx_bytes(rx_bytes), .i_rx_last(rx_last),
		.o_tx_valid(tx_valid), .i_tx_ready(tx_ready),
		.o_tx_data(tx_data), .o_tx_bytes(tx_bytes), .o_tx_last(tx_last)
	);

	//////////////////////////////////////////////////
	// Drivers and capture
	//////////////////////////////////////////////////

	// Walk the send list one beat per handshake
	always @(posedge clk)
	begin : drive_rx
		logic [34:0] w;
		int          id;
		for (int p = 0; p < NETH; p++)
		begin
			if (rx_valid[p] && rx_ready[p])
			begin
				beat_pos[p]++;
				if (beat_pos[p] == flen[send_id[p][send_pos[p]]])
				begin
					send_pos[p]++;
					beat_pos[p] = 0;
				end
			end
			if (send_pos[p] < send_n[p])
			begin
				id = send_id[p][send_pos[p]];
				w  = fmem[fbase[id] + beat_pos[p]];
				rx_valid[p] <= 1'b1;
				rx_data[p]  <= w[31:0];
				rx_bytes[p] <= w[33:32];
				rx_last[p]  <= w[34];
			end
			else
				rx_valid[p] <= 1'b0;
		end
	end

	// Capture transmit beats, ready high three cycles in four
	always @(posedge clk)
	begin : capture_tx
		int rnd;
		for (int p = 0; p < NETH; p++)
		begin
			if (!reset && tx_valid[p] && tx_ready[p] && ncap[p] < MAXB)
			begin
				cap[p][ncap[p]] = {tx_last[p], tx_bytes[p], tx_data[p]};
				ncap[p]++;
			end
			rnd = $random(seed);
			tx_ready[p] <= (rnd[1:0] != 2'b00);
		end
	end

	//////////////////////////////////////////////////
	// Frames and the route table model
	//////////////////////////////////////////////////

	// Header by the frame layout, beat 3 tags the source port
	task automatic build_frame(input int src, input mac_t dst, input mac_t smac,
		input int nbeats, output int id);
		beat_t  b;
		bytes_t nb;
		id        = nfrm;
		fbase[id] = nbeat;
		flen[id]  = nbeats;
		for (int k = 0; k < nbeats; k++)
		begin
			case (k)
			0: b = dst[47:16];
			1: b = {dst[15:0], smac[47:32]};
			2: b = smac[31:0];
			3: b = {16'(id), 8'(nbeats), 8'(src)};
			default: b = {8'(id), 8'(k), 8'h3c, 8'(id * 5 + k)};
			endcase
			// Only the last beat may be short
			nb = (k == nbeats - 1) ? bytes_t'(id) : '0;
			fmem[nbeat] = {(k == nbeats - 1), nb, b};
			nbeat++;
		end
		nfrm++;
	endtask

	function automatic int find_entry(input mac_t mac);
		int idx;
		idx = -1;
		for (int i = 0; i < NROUTE; i++)
			if (idx < 0 && m_valid[i] && m_mac[i] == mac)
				idx = i;
		return idx;
	endfunction

	// Known MAC moves, a new one takes the oldest slot
	task automatic learn_entry(input mac_t mac, input int port);
		int slot;
		slot = find_entry(mac);
		if (slot < 0)
		begin
			slot   = m_wptr;
			m_wptr = (m_wptr + 1) % NROUTE;
		end
		m_valid[slot] = 1'b1;
		m_mac[slot]   = mac;
		m_port[slot]  = port_idx_t'(port);
	endtask

	// Predict the destinations, then queue the frame on its port
	task automatic send_frame(input int src, input mac_t dst, input mac_t smac, input int nbeats);
		int         id;
		int         slot;
		port_mask_t mask;
		build_frame(src, dst, smac, nbeats, id);
		if (!port_off[src])
		begin
			slot = find_entry(dst);
			mask = (slot >= 0) ? (port_mask_t'(1) << m_port[slot]) : '1;
			mask = mask & ~(port_mask_t'(1) << src) & ~port_off;
			for (int d = 0; d < NETH; d++)
				if (mask[d])
				begin
					exp_id[d][src][exp_n[d][src]] = id;
					exp_n[d][src]++;
				end
			learn_entry(smac, src);
		end
		send_id[src][send_n[src]] = id;
		send_n[src]++;
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	function automatic bit frames_sent();
		bit ok;
		ok = 1'b1;
		for (int p = 0; p < NETH; p++)
			if (!port_off[p] && send_pos[p] < send_n[p])
				ok = 1'b0;
		return ok;
	endfunction

	function automatic bit beats_arrived();
		int want;
		bit ok;
		ok = 1'b1;
		for (int d = 0; d < NETH; d++)
		begin
			want = 0;
			for (int s = 0; s < NETH; s++)
				for (int i = 0; i < exp_n[d][s]; i++)
					want += flen[exp_id[d][s][i]];
			if (ncap[d] < want)
				ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic check_off_ready();
		for (int p = 0; p < NETH; p++)
			if (port_off[p])
				assert (!rx_ready[p]) else
				begin
					errors++;
					$display("error: o_rx_ready[%0d] got %h expected 0", p, rx_ready[p]);
				end
	endtask

	task automatic check_beat(input int d, input int k, input logic [34:0] got,
		input logic [34:0] want);
		checks++;
		assert (got[31:0] == want[31:0]) else
		begin
			errors++;
			$display("error: o_tx_data[%0d] beat %0d got %h expected %h",
				d, k, got[31:0], want[31:0]);
		end
		assert (got[33:32] == want[33:32]) else
		begin
			errors++;
			$display("error: o_tx_bytes[%0d] beat %0d got %h expected %h",
				d, k, got[33:32], want[33:32]);
		end
		assert (got[34] == want[34]) else
		begin
			errors++;
			$display("error: o_tx_last[%0d] beat %0d got %h expected %h", d, k, got[34], want[34]);
		end
	endtask

	// Frames from one source keep their order, sources may merge
	task automatic compare_port_frames(input int d);
		int pos;
		int s;
		int id;
		int rd [NETH];
		bit stop;
		pos  = 0;
		stop = 1'b0;
		for (int i = 0; i < NETH; i++)
			rd[i] = 0;
		while (!stop && pos < ncap[d])
		begin
			s = (pos + 3 < ncap[d]) ? int'(cap[d][pos + 3][7:0]) : NETH;
			assert ((s < NETH) ? (rd[s] < exp_n[d][s]) : 1'b0) else
			begin
				errors++;
				$display("port %0d sent a frame that was not expected there", d);
				stop = 1'b1;
			end
			if (!stop)
			begin
				id = exp_id[d][s][rd[s]];
				rd[s]++;
				assert (pos + flen[id] <= ncap[d]) else
				begin
					errors++;
					$display("port %0d stopped in the middle of a frame", d);
				end
				for (int k = 0; k < flen[id]; k++)
					if (pos + k < ncap[d])
						check_beat(d, k, cap[d][pos + k], fmem[fbase[id] + k]);
				pos = pos + flen[id];
			end
		end
		for (int i = 0; i < NETH; i++)
			assert (rd[i] == exp_n[d][i]) else
			begin
				errors++;
				$display("port %0d is missing %0d frames from port %0d", d, exp_n[d][i] - rd[i], i);
			end
	endtask

	// Wait for the predicted beats, let stray beats show, then compare
	task automatic deliver_and_check();
		int cyc;
		cyc = 0;
		while (!(frames_sent() && beats_arrived()) && cyc < TIMEOUT)
		begin
			@(negedge clk);
			cyc++;
			check_off_ready();
		end
		assert (frames_sent() && beats_arrived()) else
		begin
			errors++;
			$display("frames were not delivered within %0d cycles", TIMEOUT);
		end
		cyc = 0;
		while (cyc < 40)
		begin
			@(negedge clk);
			cyc++;
			check_off_ready();
		end
		for (int d = 0; d < NETH; d++)
			compare_port_frames(d);
		for (int p = 0; p < NETH; p++)
			if (port_off[p])
				assert (send_pos[p] == 0 && beat_pos[p] == 0) else
				begin
					errors++;
					$display("port %0d accepted a beat while it was off", p);
				end
		// Empty bookkeeping for the next test
		for (int p = 0; p < NETH; p++)
		begin
			send_n[p]   = 0;
			send_pos[p] = 0;
			beat_pos[p] = 0;
			ncap[p]     = 0;
			for (int s = 0; s < NETH; s++)
				exp_n[p][s] = 0;
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic flood_unknown_dest();
		$display("test 1: flood from port 0");
		send_frame(0, MAC_UNK + 1, MAC_S0, 6);
		deliver_and_check();
	endtask

	task automatic learn_source();
		$display("test 2: learn A on port 2");
		send_frame(2, MAC_UNK + 2, MAC_A, 5);
		deliver_and_check();
		send_frame(0, MAC_A, MAC_S0, 7);
		deliver_and_check();
	endtask

	// Dropped frame first, the marker must be the only arrival
	task automatic drop_own_port();
		$display("test 3: own-port drop");
		send_frame(2, MAC_A, MAC_S2, 5);
		send_frame(2, MAC_UNK + 3, MAC_A, 4);
		deliver_and_check();
	endtask

	task automatic disable_port();
		int cyc;
		$display("test 4: port 3 off");
		@(posedge clk);
		port_off <= 4'b1000;
		cyc = 0;
		while (cyc < 3)
		begin
			@(negedge clk);
			cyc++;
		end
		send_frame(0, MAC_UNK + 4, MAC_S0, 5);
		// Offered on the off port and never taken
		send_frame(3, MAC_UNK + 5, MAC_S3, 4);
		deliver_and_check();
		@(posedge clk);
		port_off <= '0;
		cyc = 0;
		while (cyc < 3)
		begin
			@(negedge clk);
			cyc++;
		end
	endtask

	task automatic merge_backpressure();
		$display("test 5: merge on port 2");
		for (int i = 0; i < 4; i++)
		begin
			send_frame(0, MAC_A, MAC_S0, 4 + i);
			send_frame(1, MAC_A, MAC_S1, 7 - i);
		end
		deliver_and_check();
	endtask

	task automatic replace_oldest();
		$display("test 6: oldest entry replaced");
		for (int i = 0; i < 9; i++)
			send_frame(3, MAC_UNK + 6, MAC_N + i, 4);
		deliver_and_check();
		send_frame(0, MAC_A, MAC_S0, 5);
		deliver_and_check();
	endtask

	initial
	begin : main
		int cyc;
		seed     = 32'h45a0_11ea;
		errors   = 0;
		checks   = 0;
		nfrm     = 0;
		nbeat    = 0;
		m_wptr   = 0;
		port_off = '0;
		rx_valid = '0;
		rx_last  = '0;
		tx_ready = '0;
		for (int p = 0; p < NETH; p++)
		begin
			rx_data[p]  = '0;
			rx_bytes[p] = '0;
			send_n[p]   = 0;
			send_pos[p] = 0;
			beat_pos[p] = 0;
			ncap[p]     = 0;
			for (int s = 0; s < NETH; s++)
				exp_n[p][s] = 0;
		end
		for (int i = 0; i < NROUTE; i++)
			m_valid[i] = 1'b0;
		cyc = 0;
		while (reset !== 1'b0 && cyc < 100)
		begin
			@(negedge clk);
			cyc++;
		end
		assert (reset === 1'b0) else
		begin
			errors++;
			$display("reset was never released");
		end
		flood_unknown_dest();
		learn_source();
		drop_own_port();
		disable_port();
		merge_backpressure();
		replace_oldest();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
common/route_pkg.sv
design/port/rx_srcmac.sv
design/port/tx_dstport.sv
design/table/route_table.sv
design/xbar/pkt_broadcast.sv
design/xbar/pkt_arbiter.sv
design/route_core.sv
tests/tb_clkgen.sv
tests/tb_route_core.sv

// File: Bender.yml
package:
  name: route_core

sources:
  - common/route_pkg.sv
  - design/port/rx_srcmac.sv
  - design/port/tx_dstport.sv
  - design/table/route_table.sv
  - design/xbar/pkt_broadcast.sv
  - design/xbar/pkt_arbiter.sv
  - design/route_core.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/tb_route_core.sv
